// ==== common/mem_bus_pkg.sv ====
// ----------------------------------------------------------
// Request and response bundles of the RAM subsystem
// ----------------------------------------------------------
package mem_bus_pkg;
    import mem_cfg_pkg::*;

    // Caller request, 24 bits
    typedef struct packed {
        logic  req;
        logic  wr;
        addr_t addr;
        data_t wr_data;
    } mem_req_t;

    // Response back to the caller, 19 bits
    typedef struct packed {
        logic  rdy;
        logic  wr_ack;
        logic  rd_ack;
        data_t rd_data;
    } mem_resp_t;

    // Clearing FSM states
    typedef enum logic [1:0] {
        CLR_IDLE = 2'd0,
        CLR_RUN  = 2'd1,
        CLR_DONE = 2'd2
    } clr_state_t;

endpackage : mem_bus_pkg

// ==== common/mem_cfg_pkg.sv ====
// ----------------------------------------------------------
// Memory configuration for the single-port RAM subsystem
// Widths, depth, latencies and the word reset value
// ----------------------------------------------------------
package mem_cfg_pkg;

    // Address and data widths
    localparam int ADDR_WID = 6;
    localparam int DEPTH    = 2 ** ADDR_WID;
    localparam int DATA_WID = 16;

    // Word address
    typedef logic [ADDR_WID-1:0] addr_t;

    // Memory word
    typedef logic [DATA_WID-1:0] data_t;

    // Value written into every word by the clearing sequence
    localparam data_t RESET_VAL = 16'h5a5a;

    // ------------------------------------------------------
    // Latencies, counted from the request cycle
    // ------------------------------------------------------
    // Accepted write to wr_ack
    localparam int WR_LATENCY = 1;

    // Accepted read to rd_ack with rd_data
    localparam int RD_LATENCY = 2;

endpackage : mem_cfg_pkg

// ==== mem_ram_sp/mem_ram_core.sv ====
// ----------------------------------------------------------
// Single-port RAM core with registered write acknowledge
// and a pipelined read path
// ----------------------------------------------------------
module mem_ram_core
    import mem_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic      mem_if,
    input  logic      rst_n,
    input  mem_req_t  core_req,
    output mem_resp_t core_resp
);

    // ------------------------------------------------------
    // Signals
    // ------------------------------------------------------
    logic wr_req;
    logic rd_req;

    // Storage
    data_t mem_array [DEPTH];

    // Write acknowledge
    logic wr_ack_q;

    // Read pipeline, stage 0 samples the array
    logic  rd_ack_q  [RD_LATENCY];
    data_t rd_data_q [RD_LATENCY];

    // ------------------------------------------------------
    // Request decode
    // ------------------------------------------------------
    assign wr_req = core_req.req && core_req.wr;
    assign rd_req = core_req.req && !core_req.wr;

    // ------------------------------------------------------
    // Write path
    // ------------------------------------------------------
    always_ff @(posedge mem_if) begin
        if (wr_req) begin
            mem_array[core_req.addr] <= core_req.wr_data;
        end
    end

    // Ack lands in the cycle after the write
    always_ff @(posedge mem_if) begin
        if (!rst_n) begin
            wr_ack_q <= 1'b0;
        end else begin
            wr_ack_q <= wr_req;
        end
    end

    // ------------------------------------------------------
    // Read path
    // ------------------------------------------------------
    always_ff @(posedge mem_if) begin
        if (!rst_n) begin
            for (int i = 0; i < RD_LATENCY; i++) begin
                rd_ack_q[i] <= 1'b0;
            end
        end else begin
            rd_ack_q[0] <= rd_req;
            for (int i = 1; i < RD_LATENCY; i++) begin
                rd_ack_q[i] <= rd_ack_q[i-1];
            end
        end
    end

    // Data follows the ack stage by stage so reads overlap
    always_ff @(posedge mem_if) begin
        if (rd_req) begin
            rd_data_q[0] <= mem_array[core_req.addr];
        end
        for (int i = 1; i < RD_LATENCY; i++) begin
            rd_data_q[i] <= rd_data_q[i-1];
        end
    end

    // ------------------------------------------------------
    // Response
    // ------------------------------------------------------
    // Core itself never stalls
    assign core_resp = '{
        rdy:     1'b1,
        wr_ack:  wr_ack_q,
        rd_ack:  rd_ack_q[RD_LATENCY-1],
        rd_data: rd_data_q[RD_LATENCY-1]
    };

    // ------------------------------------------------------
    // Assertions
    // ------------------------------------------------------
    a_rd_ack_origin : assert property (
        @(posedge mem_if) disable iff (!rst_n)
        core_resp.rd_ack |-> $past(rd_req, RD_LATENCY)
    ) else $error("rd_ack without a read request RD_LATENCY cycles earlier");

endmodule : mem_ram_core

// ==== mem_ram_sp/mem_ram_sp.sv ====
// ----------------------------------------------------------
// Single-port RAM subsystem with built-in clearing on reset
// ----------------------------------------------------------
module mem_ram_sp
    import mem_bus_pkg::*;
(
    input  logic      mem_if,
    input  logic      rst_n,
    input  mem_req_t  req_in,
    output mem_resp_t resp_out
);

    mem_req_t  core_req;
    mem_resp_t core_resp;
    logic      fsm_rdy;
    logic      fsm_wr_ack;

    // Clearing FSM in front of the core
    mem_reset_fsm i_mem_reset_fsm (
        .mem_if      ( mem_if ),
        .rst_n       ( rst_n ),
        .req_in      ( req_in ),
        .core_wr_ack ( core_resp.wr_ack ),
        .core_req    ( core_req ),
        .rdy         ( fsm_rdy ),
        .wr_ack      ( fsm_wr_ack )
    );

    // Storage and read pipeline
    mem_ram_core i_mem_ram_core (
        .mem_if    ( mem_if ),
        .rst_n     ( rst_n ),
        .core_req  ( core_req ),
        .core_resp ( core_resp )
    );

    // Read side goes straight through, write side via the FSM
    assign resp_out = '{
        rdy:     fsm_rdy & core_resp.rdy,
        wr_ack:  fsm_wr_ack,
        rd_ack:  core_resp.rd_ack,
        rd_data: core_resp.rd_data
    };

endmodule : mem_ram_sp

// ==== project.f ====
common/mem_cfg_pkg.sv
common/mem_bus_pkg.sv
source/mem_reset_fsm.sv
mem_ram_sp/mem_ram_core.sv
mem_ram_sp/mem_ram_sp.sv
test/tb_mem_ram_sp.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RAM subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_mem_ram_sp \
    -Mdir obj_dir -o tb_mem_ram_sp > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_mem_ram_sp > sim.log 2>&1
cat sim.log

grep -q "Simulation PASSED" sim.log && echo "Run passed" \
    || { echo "Run failed, see sim.log"; exit 1; }

// ==== source/mem_reset_fsm.sv ====
// ----------------------------------------------------------
// Clearing FSM that writes RESET_VAL into every word after
// reset and then hands the RAM port over to the caller
// ----------------------------------------------------------
module mem_reset_fsm
    import mem_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic     mem_if,
    input  logic     rst_n,
    input  mem_req_t req_in,
    input  logic     core_wr_ack,
    output mem_req_t core_req,
    output logic     rdy,
    output logic     wr_ack
);

    // ------------------------------------------------------
    // Signals
    // ------------------------------------------------------
    clr_state_t state;
    clr_state_t state_nxt;

    // Clearing address and a flag for the last write issued
    addr_t clr_addr;
    logic  last_sent;

    // ------------------------------------------------------
    // State machine
    // ------------------------------------------------------
    always_ff @(posedge mem_if) begin
        if (!rst_n) begin
            state <= CLR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            CLR_IDLE: state_nxt = CLR_RUN;
            // Leave only once the final clearing write is acknowledged
            CLR_RUN: begin
                if (last_sent && core_wr_ack) begin
                    state_nxt = CLR_DONE;
                end
            end
            CLR_DONE: state_nxt = CLR_DONE;
            default:  state_nxt = CLR_IDLE;
        endcase
    end

    // Address counter, holds at the top address after the last write
    always_ff @(posedge mem_if) begin
        if (!rst_n) begin
            clr_addr  <= '0;
            last_sent <= 1'b0;
        end else if (state == CLR_RUN && !last_sent) begin
            if (clr_addr == addr_t'(DEPTH - 1)) begin
                last_sent <= 1'b1;
            end else begin
                clr_addr <= clr_addr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------
    // Request mux
    // ------------------------------------------------------
    always_comb begin
        core_req = '0;
        case (state)
            CLR_RUN: begin
                core_req.req     = !last_sent;
                core_req.wr      = 1'b1;
                core_req.addr    = clr_addr;
                core_req.wr_data = RESET_VAL;
            end
            // Caller owns the port with no added latency
            CLR_DONE: core_req = req_in;
            default:  core_req = '0;
        endcase
    end

    assign rdy = (state == CLR_DONE);

    // Clearing writes never reach the caller as acknowledges
    assign wr_ack = core_wr_ack && (state == CLR_DONE);

    // ------------------------------------------------------
    // Assertions
    // ------------------------------------------------------
    a_no_req_while_busy : assert property (
        @(posedge mem_if) disable iff (!rst_n)
        !rdy |-> !req_in.req
    ) else $error("caller request while rdy is low");

    // Full sweep of the array before handing over
    a_clear_complete : assert property (
        @(posedge mem_if) disable iff (!rst_n)
        $rose(state == CLR_DONE) |->
            $past(state == CLR_RUN, DEPTH) && ($past(clr_addr) == addr_t'(DEPTH - 1))
    ) else $error("clearing sequence left CLR_RUN early");

endmodule : mem_reset_fsm

// ==== test/mem_input.dat ====
# op addr wr_data exp_rd_data, all hex; op W = write, R = read, X = re-reset
# exp_rd_data is checked on R lines only
R 00 0000 5a5a
R 3f 0000 5a5a
R 15 0000 5a5a
W 03 1234 0000
W 04 beef 0000
R 03 0000 1234
R 04 0000 beef
W 10 a5c3 0000
R 10 0000 a5c3
W 11 0f0f 0000
R 11 0000 0f0f
R 10 0000 a5c3
R 03 0000 1234
R 12 0000 5a5a
W 3f ffff 0000
R 3f 0000 ffff
W 20 0001 0000
W 21 0002 0000
W 22 0003 0000
R 20 0000 0001
R 21 0000 0002
R 22 0000 0003
R 00 0000 5a5a
X 00 0000 0000
R 03 0000 5a5a
R 10 0000 5a5a
R 3f 0000 5a5a
R 21 0000 5a5a
W 07 c001 0000
R 07 0000 c001

// ==== test/tb_mem_ram_sp.sv ====
// ----------------------------------------------------------
// Testbench for the single-port RAM subsystem
// Replays operations from a data file and checks every ack
// ----------------------------------------------------------
module tb_mem_ram_sp
    import mem_cfg_pkg::*, mem_bus_pkg::*;
();

    localparam int    RST_CYCLES = 16;
    localparam string STIM_FILE  = "test/mem_input.dat";

    logic      mem_if;
    logic      rst_n;
    mem_req_t  req_in;
    mem_resp_t resp_out;

    int cyc;
    int n_value_err;
    int n_other_err;
    int wd_cycles;
    bit ready_seen;
    bit loaded;

    // Outstanding acknowledges, in request order
    int    wr_cyc_q [$];
    int    rd_cyc_q [$];
    data_t rd_exp_q [$];

    // Operations read from the data file
    logic [7:0] op_q    [$];
    addr_t      addr_q  [$];
    data_t      wdata_q [$];
    data_t      expd_q  [$];

    mem_ram_sp dut0 (
        .mem_if   ( mem_if ),
        .rst_n    ( rst_n ),
        .req_in   ( req_in ),
        .resp_out ( resp_out )
    );

    initial begin
        mem_if = 1'b0;
        forever #2 mem_if = ~mem_if;
    end

    // ------------------------------------------------------
    // Reporting
    // ------------------------------------------------------
    task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        n_value_err++;
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, sig, exp_val, got_val);
    endtask

    task automatic report_error(input string msg);
        n_other_err++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // ------------------------------------------------------
    // Per-cycle checking
    // ------------------------------------------------------
    task automatic check_acks();
        int    exp_cyc;
        data_t exp_data;
        if (resp_out.wr_ack === 1'b1) begin
            if (wr_cyc_q.size() == 0) begin
                report_error("wr_ack with no write outstanding");
            end else begin
                exp_cyc = wr_cyc_q.pop_front();
                if (exp_cyc != cyc) begin
                    report_mismatch("wr_ack cycle", 32'(exp_cyc), 32'(cyc));
                end
            end
        end else if (wr_cyc_q.size() != 0 && wr_cyc_q[0] <= cyc) begin
            report_error("write was never acknowledged");
            exp_cyc = wr_cyc_q.pop_front();
        end

        if (resp_out.rd_ack === 1'b1) begin
            if (rd_cyc_q.size() == 0) begin
                report_error("rd_ack with no read outstanding");
            end else begin
                exp_cyc  = rd_cyc_q.pop_front();
                exp_data = rd_exp_q.pop_front();
                if (exp_cyc != cyc) begin
                    report_mismatch("rd_ack cycle", 32'(exp_cyc), 32'(cyc));
                end
                if (resp_out.rd_data !== exp_data) begin
                    report_mismatch("rd_data", 32'(exp_data), 32'(resp_out.rd_data));
                end
            end
        end else if (rd_cyc_q.size() != 0 && rd_cyc_q[0] <= cyc) begin
            report_error("read was never acknowledged");
            exp_cyc  = rd_cyc_q.pop_front();
            exp_data = rd_exp_q.pop_front();
        end

        // Once up, rdy stays up until the next reset
        if (ready_seen && resp_out.rdy !== 1'b1) begin
            report_mismatch("rdy", 32'(1), 32'(resp_out.rdy));
        end
    endtask

    // Outputs are sampled and inputs driven 1 unit after the edge
    task automatic step_cycle();
        @(posedge mem_if);
        #1;
        cyc++;
        check_acks();
    endtask

    // ------------------------------------------------------
    // Reset and clearing
    // ------------------------------------------------------
    task automatic apply_reset();
        rst_n      = 1'b0;
        req_in     = '0;
        ready_seen = 1'b0;
        repeat (RST_CYCLES) step_cycle();
        if (resp_out.rdy !== 1'b0) begin
            report_mismatch("rdy", 32'(0), 32'(resp_out.rdy));
        end
        if (resp_out.wr_ack !== 1'b0) begin
            report_mismatch("wr_ack", 32'(0), 32'(resp_out.wr_ack));
        end
        if (resp_out.rd_ack !== 1'b0) begin
            report_mismatch("rd_ack", 32'(0), 32'(resp_out.rd_ack));
        end
        rst_n = 1'b1;
    endtask

    task automatic wait_clear_done();
        int n;
        // First edge with rst_n high starts the sweep
        step_cycle();
        n = 0;
        while (resp_out.rdy !== 1'b1 && n < DEPTH + 16) begin
            step_cycle();
            n++;
        end
        if (resp_out.rdy !== 1'b1) begin
            report_error("rdy never rose after reset");
        end else begin
            if (n != DEPTH + 1) begin
                report_mismatch("rdy rise delay", 32'(DEPTH + 1), 32'(n));
            end
            ready_seen = 1'b1;
        end
    endtask

    // Wait for every outstanding ack, bounded by the read latency
    task automatic drain_acks();
        int guard;
        guard = 0;
        while ((wr_cyc_q.size() != 0 || rd_cyc_q.size() != 0) && guard < RD_LATENCY + 4) begin
            step_cycle();
            guard++;
        end
        if (wr_cyc_q.size() != 0 || rd_cyc_q.size() != 0) begin
            report_error("acknowledges still outstanding at drain");
            wr_cyc_q.delete();
            rd_cyc_q.delete();
            rd_exp_q.delete();
        end
    endtask

    // ------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------
    task automatic issue_op(input logic [7:0] op, input addr_t a, input data_t wd,
                            input data_t ed);
        if (resp_out.rdy !== 1'b1) begin
            report_error("request driven while rdy is low");
        end
        req_in.req     = 1'b1;
        req_in.wr      = (op == "W");
        req_in.addr    = a;
        req_in.wr_data = wd;
        // Latency counts from this request cycle
        if (op == "W") begin
            wr_cyc_q.push_back(cyc + WR_LATENCY);
        end else begin
            rd_cyc_q.push_back(cyc + RD_LATENCY);
            rd_exp_q.push_back(ed);
        end
        step_cycle();
        req_in = '0;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n_fields;
        string       text;
        string       op_str;
        logic [31:0] a_raw;
        logic [31:0] wd_raw;
        logic [31:0] ed_raw;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_error("cannot open the stimulus file");
            return;
        end
        while ($fgets(text, fd) != 0) begin
            // Skip comments and blank lines
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            n_fields = $sscanf(text, "%s %h %h %h", op_str, a_raw, wd_raw, ed_raw);
            if (n_fields != 4 || !(op_str == "W" || op_str == "R" || op_str == "X")) begin
                report_error("malformed line in the stimulus file");
                continue;
            end
            op_q.push_back(op_str[0]);
            addr_q.push_back(addr_t'(a_raw));
            wdata_q.push_back(data_t'(wd_raw));
            expd_q.push_back(data_t'(ed_raw));
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------
    initial begin
        int gap;
        rst_n       = 1'b0;
        req_in      = '0;
        cyc         = 0;
        n_value_err = 0;
        n_other_err = 0;
        ready_seen  = 1'b0;
        loaded      = 1'b0;
        void'($urandom(32'hbd82));

        load_stimulus();
        if (op_q.size() == 0) begin
            report_error("no operations in the stimulus file");
        end
        wd_cycles = op_q.size() * 8 + 4 * DEPTH + 200;
        loaded    = 1'b1;

        apply_reset();
        wait_clear_done();

        foreach (op_q[i]) begin
            // Reads go back to back, writes and re-resets after a random gap
            if (op_q[i] != "R") begin
                gap = $urandom % 4;
                repeat (gap) step_cycle();
            end
            if (op_q[i] == "X") begin
                drain_acks();
                apply_reset();
                wait_clear_done();
            end else begin
                issue_op(op_q[i], addr_q[i], wdata_q[i], expd_q[i]);
            end
        end
        drain_acks();

        $display("Run complete: %0d value errors, %0d other errors", n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        #(wd_cycles * 4);
        $display("Watchdog expired after %0d cycles, the run did not complete", wd_cycles);
        $display("Run stopped: %0d value errors, %0d other errors", n_value_err, n_other_err);
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_mem_ram_sp
